// ==== core_consts.svh ====
/*
 * core constants
 * reset vector, NOP encoding and the RV32I opcode and funct3 values
 */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

`define XLEN		32
`define REG_NUM		32
`define RESET_PC	32'h0000_0000
`define NOP_INSTR	32'h0000_0013	// addi x0, x0, 0

`define OPC_LUI		7'b0110111
`define OPC_AUIPC	7'b0010111
`define OPC_JAL		7'b1101111
`define OPC_JALR	7'b1100111
`define OPC_BRANCH	7'b1100011
`define OPC_LOAD	7'b0000011
`define OPC_STORE	7'b0100011
`define OPC_OP_IMM	7'b0010011
`define OPC_OP		7'b0110011

`define F3_ADD		3'b000	// also sub
`define F3_SLL		3'b001
`define F3_SLT		3'b010
`define F3_SLTU		3'b011
`define F3_XOR		3'b100
`define F3_SR		3'b101	// srl / sra
`define F3_OR		3'b110
`define F3_AND		3'b111

`define F3_BEQ		3'b000
`define F3_BNE		3'b001
`define F3_BLT		3'b100
`define F3_BGE		3'b101

`define F3_LW		3'b010
`define F3_LBU		3'b100
`define F3_SW		3'b010
`define F3_SB		3'b000

`endif

// ==== core_pkg.sv ====
/*
 * core_pkg
 * data types shared by the stages of the three-stage RV32I core
 */
`include "core_consts.svh"

package core_pkg;

	typedef logic [`XLEN-1:0]			word_t;
	typedef logic [`XLEN-1:0]			addr_t;
	typedef logic [31:0]				instr_t;
	typedef logic [$clog2(`REG_NUM)-1:0]	reg_addr_t;
	typedef logic [`XLEN/8-1:0]			strb_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_SLT,
		ALU_SLTU
	} alu_op_e;

	typedef enum logic [2:0] {
		JMP_NONE,
		JMP_JAL,
		JMP_JALR,
		JMP_BEQ,
		JMP_BNE,
		JMP_BLT,
		JMP_BGE
	} jmp_flag_e;

	typedef enum logic [1:0] {LD_NONE, LD_LW, LD_LBU} load_code_e;
	typedef enum logic [1:0] {ST_NONE, ST_SW, ST_SB} store_code_e;

	// ordered by severity, compared with < in the stages
	typedef enum logic [1:0] {
		HOLD_NONE,
		HOLD_PC,	// fetch not ready
		HOLD_ID,	// load-use
		HOLD_EX		// data side not ready
	} hold_code_e;

	typedef struct packed {
		alu_op_e		alu_op;
		word_t			op_a;
		word_t			op_b;
		word_t			store_data;
		reg_addr_t		rd;
		logic			reg_wr_en;
		load_code_e		load_code;
		store_code_e	store_code;
	} id_ex_t;

	typedef struct packed {
		jmp_flag_e	flag;
		word_t		rs1;
		word_t		rs2;
		addr_t		addr;	// address of the jump itself
		word_t		imm;
	} jmp_req_t;

endpackage

// ==== pc.sv ====
/*
 * pc
 * fetch address register, redirected by the controller or advanced by 4
 */
`timescale 1ns/1ps
`include "core_consts.svh"

module pc (
	input	logic					clk,
	input	logic					rst_n_i,
	input	core_pkg::hold_code_e	hold_code_i,
	input	logic					jmp_en_i,
	input	core_pkg::addr_t		jmp_to_i,
	output	core_pkg::addr_t		pc_o
);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pc_o <= `RESET_PC;
		end else if (jmp_en_i) begin
			pc_o <= jmp_to_i;	// taken jump from decode
		end else if (hold_code_i == core_pkg::HOLD_NONE) begin
			pc_o <= pc_o + core_pkg::addr_t'(4);
		end
	end

	// jalr targets come from register data
	assert property (@(posedge clk) disable iff (!rst_n_i)
		jmp_en_i |=> (pc_o[1:0] == 2'b00))
		else $error("pc: misaligned jump target %h", pc_o);

endmodule

// ==== if_stage.sv ====
/*
 * if_stage
 * IF/ID instruction register, masks the wrong path and stalled fetches to a NOP
 */
`timescale 1ns/1ps
`include "core_consts.svh"

module if_stage (
	input	logic					clk,
	input	logic					rst_n_i,
	input	core_pkg::hold_code_e	hold_code_i,
	input	logic					instr_mask_i,
	input	core_pkg::instr_t		instr_i,
	input	core_pkg::addr_t		addr_instr_i,
	output	core_pkg::instr_t		instr_o,
	output	core_pkg::addr_t		addr_instr_o,
	output	logic					instr_rd_en_o
);

	logic load_en;
	logic bubble;

	assign load_en = hold_code_i < core_pkg::HOLD_ID;
	assign bubble = instr_mask_i || (hold_code_i == core_pkg::HOLD_PC);
	assign instr_rd_en_o = hold_code_i == core_pkg::HOLD_NONE;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			instr_o <= `NOP_INSTR;
			addr_instr_o <= `RESET_PC;
		end else if (load_en) begin
			instr_o <= bubble ? `NOP_INSTR : instr_i;
			addr_instr_o <= addr_instr_i;
		end
	end

endmodule

// ==== id_stage.sv ====
/*
 * id_stage
 * instruction decode with EX forwarding and load-use detection,
 * followed by the ID/EX pipeline register
 */
`timescale 1ns/1ps
`include "core_consts.svh"

module id_stage (
	input	logic					clk,
	input	logic					rst_n_i,
	input	core_pkg::hold_code_e	hold_code_i,
	input	core_pkg::instr_t		instr_i,
	input	core_pkg::addr_t		addr_instr_i,
	input	core_pkg::word_t		data_rs1_i,
	input	core_pkg::word_t		data_rs2_i,
	input	core_pkg::word_t		data_bypass_i,
	output	core_pkg::reg_addr_t	addr_rs1_o,
	output	core_pkg::reg_addr_t	addr_rs2_o,
	output	core_pkg::id_ex_t		id_ex_o,
	output	core_pkg::jmp_req_t		jmp_req_o,
	output	logic					load_bypass_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	core_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;
	core_pkg::word_t jmp_imm;
	core_pkg::word_t rs1_val;
	core_pkg::word_t rs2_val;
	logic fwd_rs1;
	logic fwd_rs2;
	logic uses_rs1;
	logic uses_rs2;
	logic known;
	core_pkg::id_ex_t dec;
	core_pkg::jmp_flag_e jmp_flag;

	function automatic core_pkg::alu_op_e alu_dec(input logic [2:0] f3, input logic alt);
		case (f3)
			`F3_ADD:	return alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
			`F3_SLL:	return core_pkg::ALU_SLL;
			`F3_SLT:	return core_pkg::ALU_SLT;
			`F3_SLTU:	return core_pkg::ALU_SLTU;
			`F3_XOR:	return core_pkg::ALU_XOR;
			`F3_SR:		return alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
			`F3_OR:		return core_pkg::ALU_OR;
			default:	return core_pkg::ALU_AND;
		endcase
	endfunction

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign addr_rs1_o = instr_i[19:15];
	assign addr_rs2_o = instr_i[24:20];

	assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
		instr_i[11:8], 1'b0};
	assign imm_u = {instr_i[31:12], 12'b0};
	assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
		instr_i[30:21], 1'b0};

	// EX result forwarding, rd is never x0 when reg_wr_en is set
	assign fwd_rs1 = id_ex_o.reg_wr_en && (id_ex_o.rd == addr_rs1_o);
	assign fwd_rs2 = id_ex_o.reg_wr_en && (id_ex_o.rd == addr_rs2_o);
	assign rs1_val = fwd_rs1 ? data_bypass_i : data_rs1_i;
	assign rs2_val = fwd_rs2 ? data_bypass_i : data_rs2_i;

	assign uses_rs1 = !(opcode inside {`OPC_LUI, `OPC_AUIPC, `OPC_JAL});
	assign uses_rs2 = opcode inside {`OPC_OP, `OPC_STORE, `OPC_BRANCH};
	assign load_bypass_o = (id_ex_o.load_code != core_pkg::LD_NONE) &&
		((uses_rs1 && fwd_rs1) || (uses_rs2 && fwd_rs2));	// load data not ready yet

	always_comb begin
		dec = '0;
		dec.op_a = rs1_val;
		dec.op_b = imm_i;
		dec.store_data = rs2_val;
		dec.rd = instr_i[11:7];
		jmp_flag = core_pkg::JMP_NONE;
		known = 1'b1;
		case (opcode)
			`OPC_LUI: begin
				dec.op_a = '0;
				dec.op_b = imm_u;
				dec.reg_wr_en = 1'b1;
			end
			`OPC_AUIPC: begin
				dec.op_a = addr_instr_i;
				dec.op_b = imm_u;
				dec.reg_wr_en = 1'b1;
			end
			`OPC_JAL, `OPC_JALR: begin
				dec.op_a = addr_instr_i;	// link value through the ALU
				dec.op_b = core_pkg::word_t'(4);
				dec.reg_wr_en = 1'b1;
				jmp_flag = (opcode == `OPC_JAL) ? core_pkg::JMP_JAL : core_pkg::JMP_JALR;
			end
			`OPC_BRANCH: begin
				case (funct3)
					`F3_BEQ:	jmp_flag = core_pkg::JMP_BEQ;
					`F3_BNE:	jmp_flag = core_pkg::JMP_BNE;
					`F3_BLT:	jmp_flag = core_pkg::JMP_BLT;
					`F3_BGE:	jmp_flag = core_pkg::JMP_BGE;
					default:	known = 1'b0;
				endcase
			end
			`OPC_LOAD: begin
				dec.reg_wr_en = 1'b1;
				if (funct3 == `F3_LW) begin
					dec.load_code = core_pkg::LD_LW;
				end else if (funct3 == `F3_LBU) begin
					dec.load_code = core_pkg::LD_LBU;
				end else begin
					known = 1'b0;
				end
			end
			`OPC_STORE: begin
				dec.op_b = imm_s;
				if (funct3 == `F3_SW) begin
					dec.store_code = core_pkg::ST_SW;
				end else if (funct3 == `F3_SB) begin
					dec.store_code = core_pkg::ST_SB;
				end else begin
					known = 1'b0;
				end
			end
			`OPC_OP_IMM: begin
				dec.alu_op = alu_dec(funct3, instr_i[30] && (funct3 == `F3_SR));
				dec.reg_wr_en = 1'b1;
			end
			`OPC_OP: begin
				dec.op_b = rs2_val;
				dec.alu_op = alu_dec(funct3, instr_i[30]);
				dec.reg_wr_en = 1'b1;
			end
			default: known = 1'b0;
		endcase
		dec.reg_wr_en = dec.reg_wr_en && known && (dec.rd != '0);
	end

	assign jmp_imm = (jmp_flag == core_pkg::JMP_JALR) ? imm_i :
		(jmp_flag == core_pkg::JMP_JAL) ? imm_j : imm_b;
	assign jmp_req_o = '{flag: jmp_flag, rs1: rs1_val, rs2: rs2_val,
		addr: addr_instr_i, imm: jmp_imm};

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			id_ex_o <= '0;
		end else if (hold_code_i == core_pkg::HOLD_ID) begin
			id_ex_o <= '0;	// bubble behind the load
		end else if (hold_code_i != core_pkg::HOLD_EX) begin
			id_ex_o <= dec;
		end
	end

	// fetch only ever hands over valid words or NOPs
	assert property (@(posedge clk) disable iff (!rst_n_i)
		(hold_code_i < core_pkg::HOLD_ID) |-> known)
		else $error("id_stage: unknown instruction %h at %h", instr_i, addr_instr_i);

endmodule

// ==== ex_stage.sv ====
/*
 * ex_stage
 * ALU, memory strobes with byte lane placement, load alignment
 * and writeback data selection
 */
`timescale 1ns/1ps

module ex_stage (
	input	core_pkg::id_ex_t		id_ex_i,
	input	core_pkg::word_t		data_mem_i,
	output	core_pkg::word_t		alu_result_o,
	output	logic					mem_rd_en_o,
	output	core_pkg::addr_t		addr_mem_rd_o,
	output	logic					mem_wr_en_o,
	output	core_pkg::addr_t		addr_mem_wr_o,
	output	core_pkg::word_t		data_mem_wr_o,
	output	core_pkg::strb_t		strb_mem_wr_o,
	output	core_pkg::reg_addr_t	rd_o,
	output	core_pkg::word_t		data_reg_wr_o,
	output	logic					reg_wr_en_o
);

	core_pkg::word_t op_a;
	core_pkg::word_t op_b;
	logic [4:0] shamt;
	logic [1:0] byte_sel;
	logic [7:0] load_byte;
	core_pkg::word_t load_data;

	assign op_a = id_ex_i.op_a;
	assign op_b = id_ex_i.op_b;
	assign shamt = op_b[4:0];

	always_comb begin
		case (id_ex_i.alu_op)
			core_pkg::ALU_ADD:	alu_result_o = op_a + op_b;
			core_pkg::ALU_SUB:	alu_result_o = op_a - op_b;
			core_pkg::ALU_AND:	alu_result_o = op_a & op_b;
			core_pkg::ALU_OR:	alu_result_o = op_a | op_b;
			core_pkg::ALU_XOR:	alu_result_o = op_a ^ op_b;
			core_pkg::ALU_SLL:	alu_result_o = op_a << shamt;
			core_pkg::ALU_SRL:	alu_result_o = op_a >> shamt;
			core_pkg::ALU_SRA:	alu_result_o = $signed(op_a) >>> shamt;
			core_pkg::ALU_SLT:	alu_result_o = core_pkg::word_t'($signed(op_a) < $signed(op_b));
			core_pkg::ALU_SLTU:	alu_result_o = core_pkg::word_t'(op_a < op_b);
			default:			alu_result_o = '0;
		endcase
	end

	// alu result doubles as the byte address
	assign byte_sel = alu_result_o[1:0];
	assign mem_rd_en_o = id_ex_i.load_code != core_pkg::LD_NONE;
	assign addr_mem_rd_o = alu_result_o;
	assign mem_wr_en_o = id_ex_i.store_code != core_pkg::ST_NONE;
	assign addr_mem_wr_o = alu_result_o;

	always_comb begin
		if (id_ex_i.store_code == core_pkg::ST_SB) begin
			data_mem_wr_o = {4{id_ex_i.store_data[7:0]}};	// byte on every lane
			strb_mem_wr_o = core_pkg::strb_t'(1) << byte_sel;
		end else if (id_ex_i.store_code == core_pkg::ST_SW) begin
			data_mem_wr_o = id_ex_i.store_data;
			strb_mem_wr_o = '1;
		end else begin
			data_mem_wr_o = id_ex_i.store_data;
			strb_mem_wr_o = '0;
		end
	end

	assign load_byte = data_mem_i[8*byte_sel +: 8];
	assign load_data = (id_ex_i.load_code == core_pkg::LD_LBU) ?
		core_pkg::word_t'(load_byte) : data_mem_i;	// lbu zero extends

	assign rd_o = id_ex_i.rd;
	assign reg_wr_en_o = id_ex_i.reg_wr_en;
	assign data_reg_wr_o = mem_rd_en_o ? load_data : alu_result_o;

endmodule

// ==== regs.sv ====
/*
 * regs
 * general register file, 31 writable entries, asynchronous reads, x0 reads zero
 */
`timescale 1ns/1ps
`include "core_consts.svh"

module regs (
	input	logic					clk,
	input	logic					rst_n_i,
	input	logic					wr_en_i,
	input	core_pkg::reg_addr_t	addr_wr_i,
	input	core_pkg::word_t		data_wr_i,
	input	core_pkg::reg_addr_t	addr_rd1_i,
	input	core_pkg::reg_addr_t	addr_rd2_i,
	output	core_pkg::word_t		data_rd1_o,
	output	core_pkg::word_t		data_rd2_o
);

	core_pkg::word_t rf [1:`REG_NUM-1];

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 1; i < `REG_NUM; i++) begin
				rf[i] <= '0;
			end
		end else if (wr_en_i && (addr_wr_i != '0)) begin
			rf[addr_wr_i] <= data_wr_i;
		end
	end

	// no write-through, the EX forward covers the back-to-back case
	assign data_rd1_o = (addr_rd1_i == '0) ? '0 : rf[addr_rd1_i];
	assign data_rd2_o = (addr_rd2_i == '0) ? '0 : rf[addr_rd2_i];

endmodule

// ==== ctrl.sv ====
/*
 * ctrl
 * branch resolution, jump target and the pipeline hold code
 */
`timescale 1ns/1ps

module ctrl (
	input	logic					clk,
	input	logic					rst_n_i,
	input	logic					stall_if_i,
	input	logic					stall_mem_i,
	input	core_pkg::jmp_req_t		jmp_req_i,
	input	core_pkg::addr_t		pc_i,
	input	logic					load_bypass_i,
	output	logic					jmp_en_o,
	output	core_pkg::addr_t		jmp_to_o,
	output	logic					instr_mask_o,
	output	core_pkg::hold_code_e	hold_code_o
);

	logic rs_eq;
	logic rs_lt;
	logic taken;
	logic redirect;

	assign rs_eq = jmp_req_i.rs1 == jmp_req_i.rs2;
	assign rs_lt = $signed(jmp_req_i.rs1) < $signed(jmp_req_i.rs2);

	always_comb begin
		case (jmp_req_i.flag)
			core_pkg::JMP_JAL,
			core_pkg::JMP_JALR:	taken = 1'b1;
			core_pkg::JMP_BEQ:	taken = rs_eq;
			core_pkg::JMP_BNE:	taken = !rs_eq;
			core_pkg::JMP_BLT:	taken = rs_lt;
			core_pkg::JMP_BGE:	taken = !rs_lt;
			default:			taken = 1'b0;
		endcase
	end

	assign jmp_to_o = (jmp_req_i.flag == core_pkg::JMP_JALR) ?
		((jmp_req_i.rs1 + jmp_req_i.imm) & ~core_pkg::addr_t'(1)) :
		(jmp_req_i.addr + jmp_req_i.imm);

	// no redirect when the fetch is already at the target
	assign redirect = taken && (jmp_to_o != pc_i);

	// the slot after a redirect is masked anyway, so a fetch stall does not hold it
	assign hold_code_o = stall_mem_i ? core_pkg::HOLD_EX :
		load_bypass_i ? core_pkg::HOLD_ID :
		(stall_if_i && !redirect) ? core_pkg::HOLD_PC : core_pkg::HOLD_NONE;

	assign jmp_en_o = redirect && (hold_code_o == core_pkg::HOLD_NONE);
	assign instr_mask_o = jmp_en_o;

	// the masked slot reaches decode as a NOP
	assert property (@(posedge clk) disable iff (!rst_n_i)
		jmp_en_o |=> !jmp_en_o)
		else $error("ctrl: back-to-back redirect");

endmodule

// ==== core.sv ====
/*
 * core
 * three-stage in-order RV32I pipeline, fetch / decode / execute
 */
`timescale 1ns/1ps

module core (
	input	logic					clk,
	input	logic					rst_n_i,
	input	logic					stall_if_i,
	input	logic					stall_mem_i,
	input	core_pkg::instr_t		instr_i,
	input	core_pkg::addr_t		addr_instr_i,
	input	core_pkg::word_t		data_mem_i,
	output	core_pkg::addr_t		pc_o,
	output	logic					instr_rd_en_o,
	output	logic					mem_wr_en_o,
	output	logic					mem_rd_en_o,
	output	core_pkg::word_t		data_mem_wr_o,
	output	core_pkg::strb_t		strb_mem_wr_o,
	output	core_pkg::addr_t		addr_mem_wr_o,
	output	core_pkg::addr_t		addr_mem_rd_o
);

	core_pkg::hold_code_e hold_code;
	logic jmp_en;
	core_pkg::addr_t jmp_to;
	logic instr_mask;
	core_pkg::instr_t instr_id;
	core_pkg::addr_t addr_instr_id;
	core_pkg::reg_addr_t addr_rs1;
	core_pkg::reg_addr_t addr_rs2;
	core_pkg::word_t data_rs1;
	core_pkg::word_t data_rs2;
	core_pkg::id_ex_t id_ex;
	core_pkg::jmp_req_t jmp_req;
	logic load_bypass;
	core_pkg::word_t alu_result;
	core_pkg::reg_addr_t rd_ex;
	core_pkg::word_t data_wr_ex;
	logic reg_wr_en_ex;
	logic reg_wr_en;

	assign reg_wr_en = reg_wr_en_ex && (hold_code < core_pkg::HOLD_EX);	// EX frozen

	pc core_pc (
		.clk			(clk),
		.rst_n_i		(rst_n_i),
		.hold_code_i	(hold_code),
		.jmp_en_i		(jmp_en),
		.jmp_to_i		(jmp_to),
		.pc_o			(pc_o)
	);

	if_stage core_if (
		.clk			(clk),
		.rst_n_i		(rst_n_i),
		.hold_code_i	(hold_code),
		.instr_mask_i	(instr_mask),
		.instr_i		(instr_i),
		.addr_instr_i	(addr_instr_i),
		.instr_o		(instr_id),
		.addr_instr_o	(addr_instr_id),
		.instr_rd_en_o	(instr_rd_en_o)
	);

	id_stage core_id (
		.clk			(clk),
		.rst_n_i		(rst_n_i),
		.hold_code_i	(hold_code),
		.instr_i		(instr_id),
		.addr_instr_i	(addr_instr_id),
		.data_rs1_i		(data_rs1),
		.data_rs2_i		(data_rs2),
		.data_bypass_i	(alu_result),
		.addr_rs1_o		(addr_rs1),
		.addr_rs2_o		(addr_rs2),
		.id_ex_o		(id_ex),
		.jmp_req_o		(jmp_req),
		.load_bypass_o	(load_bypass)
	);

	ex_stage core_ex (
		.id_ex_i		(id_ex),
		.data_mem_i		(data_mem_i),
		.alu_result_o	(alu_result),
		.mem_rd_en_o	(mem_rd_en_o),
		.addr_mem_rd_o	(addr_mem_rd_o),
		.mem_wr_en_o	(mem_wr_en_o),
		.addr_mem_wr_o	(addr_mem_wr_o),
		.data_mem_wr_o	(data_mem_wr_o),
		.strb_mem_wr_o	(strb_mem_wr_o),
		.rd_o			(rd_ex),
		.data_reg_wr_o	(data_wr_ex),
		.reg_wr_en_o	(reg_wr_en_ex)
	);

	regs general_regs (
		.clk			(clk),
		.rst_n_i		(rst_n_i),
		.wr_en_i		(reg_wr_en),
		.addr_wr_i		(rd_ex),
		.data_wr_i		(data_wr_ex),
		.addr_rd1_i		(addr_rs1),
		.addr_rd2_i		(addr_rs2),
		.data_rd1_o		(data_rs1),
		.data_rd2_o		(data_rs2)
	);

	ctrl core_ctrl (
		.clk			(clk),
		.rst_n_i		(rst_n_i),
		.stall_if_i		(stall_if_i),
		.stall_mem_i	(stall_mem_i),
		.jmp_req_i		(jmp_req),
		.pc_i			(pc_o),
		.load_bypass_i	(load_bypass),
		.jmp_en_o		(jmp_en),
		.jmp_to_o		(jmp_to),
		.instr_mask_o	(instr_mask),
		.hold_code_o	(hold_code)
	);

endmodule

// ==== core_checker.sv ====
/*
 * core_checker
 * watches completed data writes and the fetch enable of the core
 * and compares them with the expected behavior
 */
`timescale 1ns/1ps

module core_checker (
	input	logic			clk,
	input	logic			rst_n_i,
	input	logic			mem_wr_en_i,
	input	logic			stall_mem_i,
	input	logic [31:0]	addr_mem_wr_i,
	input	logic [31:0]	data_mem_wr_i,
	input	logic [3:0]		strb_mem_wr_i,
	input	logic [31:0]	pc_i,
	input	logic			instr_rd_en_i,
	output	logic			done_o,
	output	int				fail_cnt_o
);

	logic [31:0] vec [0:255];
	int rec_base;
	int rec_num;
	int idx;
	int pass_cnt;
	logic [31:0] pc_q;
	logic rd_en_q;
	logic fetch_seen;

	initial begin
		done_o = 1'b0;
		fail_cnt_o = 0;
		pass_cnt = 0;
		idx = 0;
		$readmemh("core_vectors.txt", vec);
		rec_num = vec[vec[0] + 1];
		rec_base = vec[0] + 2;	// first record after the store count
		wait (rst_n_i === 1'b1);
		wait (idx == rec_num);
		repeat (20) @(posedge clk);	// room for stray stores
		$display("checks done: %0d stores passed, %0d failed", pass_cnt, fail_cnt_o);
		done_o = 1'b1;
	end

	always @(posedge clk) begin
		logic [31:0] exp_addr;
		logic [31:0] exp_data;
		logic [31:0] exp_strb;
		logic bad;
		if (!rst_n_i) begin
			fetch_seen = 1'b0;
		end else begin
			// pc moves on exactly the edges after a fetch enable
			if (fetch_seen && !done_o && ((pc_i !== pc_q) !== rd_en_q)) begin
				$display("mismatch instr_rd_en_o at pc %h: got %h expected %h",
					pc_q, rd_en_q, pc_i !== pc_q);
				fail_cnt_o = fail_cnt_o + 1;
			end
			pc_q = pc_i;
			rd_en_q = instr_rd_en_i;
			fetch_seen = 1'b1;
			if (mem_wr_en_i && !stall_mem_i) begin
				if (idx >= rec_num) begin
					$display("unexpected store to address %h after the last expected one",
						addr_mem_wr_i);
					fail_cnt_o = fail_cnt_o + 1;
				end else begin
					exp_addr = vec[rec_base + 3*idx];
					exp_data = vec[rec_base + 3*idx + 1];
					exp_strb = vec[rec_base + 3*idx + 2];
					bad = 1'b0;
					if (addr_mem_wr_i !== exp_addr) begin
						$display("mismatch addr_mem_wr_o store %0d: got %h expected %h",
							idx, addr_mem_wr_i, exp_addr);
						bad = 1'b1;
					end
					if (data_mem_wr_i !== exp_data) begin
						$display("mismatch data_mem_wr_o store %0d: got %h expected %h",
							idx, data_mem_wr_i, exp_data);
						bad = 1'b1;
					end
					if (strb_mem_wr_i !== exp_strb[3:0]) begin
						$display("mismatch strb_mem_wr_o store %0d: got %h expected %h",
							idx, strb_mem_wr_i, exp_strb[3:0]);
						bad = 1'b1;
					end
					if (bad) begin
						fail_cnt_o = fail_cnt_o + 1;
					end else begin
						$display("store %0d ok: %h <= %h strb %h", idx, addr_mem_wr_i,
							data_mem_wr_i, strb_mem_wr_i);
						pass_cnt = pass_cnt + 1;
					end
					idx = idx + 1;
				end
			end
		end
	end

endmodule

// ==== tb_core.sv ====
/*
 * tb_core
 * testbench for the RV32I core: memory models, random stalls,
 * program loading and watchdog
 */
`timescale 1ns/1ps
`include "core_consts.svh"

module tb_core;

	logic clk;
	logic rst_n_i;
	logic stall_if_i;
	logic stall_mem_i;
	logic [31:0] instr_i;
	logic [31:0] addr_instr_i;
	logic [31:0] data_mem_i;
	logic [31:0] pc_o;
	logic instr_rd_en_o;
	logic mem_wr_en_o;
	logic mem_rd_en_o;
	logic [31:0] data_mem_wr_o;
	logic [3:0] strb_mem_wr_o;
	logic [31:0] addr_mem_wr_o;
	logic [31:0] addr_mem_rd_o;
	logic [31:0] vec [0:255];
	logic [31:0] dmem [0:63];
	logic [31:0] rnd;
	int prog_len;
	logic done;
	int fail_cnt;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	core DUT (
		.clk(clk), .rst_n_i(rst_n_i), .stall_if_i(stall_if_i), .stall_mem_i(stall_mem_i),
		.instr_i(instr_i), .addr_instr_i(addr_instr_i), .data_mem_i(data_mem_i),
		.pc_o(pc_o), .instr_rd_en_o(instr_rd_en_o), .mem_wr_en_o(mem_wr_en_o),
		.mem_rd_en_o(mem_rd_en_o), .data_mem_wr_o(data_mem_wr_o),
		.strb_mem_wr_o(strb_mem_wr_o), .addr_mem_wr_o(addr_mem_wr_o),
		.addr_mem_rd_o(addr_mem_rd_o)
	);

	core_checker store_check (
		.clk(clk), .rst_n_i(rst_n_i), .mem_wr_en_i(mem_wr_en_o), .stall_mem_i(stall_mem_i),
		.addr_mem_wr_i(addr_mem_wr_o), .data_mem_wr_i(data_mem_wr_o),
		.strb_mem_wr_i(strb_mem_wr_o), .pc_i(pc_o), .instr_rd_en_i(instr_rd_en_o),
		.done_o(done), .fail_cnt_o(fail_cnt)
	);

	always #5 clk = ~clk;

	// program sits at vec[1..prog_len]
	assign addr_instr_i = pc_o;
	assign instr_i = ((pc_o >> 2) < prog_len) ? vec[(pc_o >> 2) + 1] : `NOP_INSTR;

	// no read data unless a read is enabled
	assign data_mem_i = mem_rd_en_o ? dmem[addr_mem_rd_o[7:2]] : 32'hdead_beef;

	always @(posedge clk) begin
		if (mem_wr_en_o && !stall_mem_i) begin
			for (int b = 0; b < 4; b++) begin
				if (strb_mem_wr_o[b]) begin
					dmem[addr_mem_wr_o[7:2]][8*b +: 8] <= data_mem_wr_o[8*b +: 8];
				end
			end
		end
	end

	// stalls about one cycle in eight each
	always @(posedge clk) begin
		if (rst_n_i) begin
			rnd = xorshift(rnd);
			stall_if_i <= rnd[2:0] == 3'd0;
			rnd = xorshift(rnd);
			stall_mem_i <= rnd[2:0] == 3'd0;
		end
	end

	initial begin
		clk = 1'b0;
		rst_n_i = 1'b0;
		stall_if_i = 1'b0;
		stall_mem_i = 1'b0;
		rnd = 32'h204d_543d;
		$readmemh("core_vectors.txt", vec);
		prog_len = vec[0];
		for (int i = 0; i < 64; i++) begin
			dmem[i] = 32'hc0de_0000 | (i * 4);
		end
		repeat (10) @(posedge clk);
		rst_n_i <= 1'b1;
		wait (done === 1'b1);
		if (fail_cnt == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	initial begin
		wait (prog_len > 0);
		repeat (10 + 20 * prog_len + 100) @(posedge clk);
		$display("program did not finish in time");
		$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== core_vectors.txt ====
// program length, program words, store count,
// then one expected store per line: address data strobe
00000025
123450B7
67808093
00102023
FFB00113
40115193
00415213
403202B3
00502223
00412333
004133B3
00431413
00144433
00802423
002000A3
00002483
00148493
00902623
00104503
00A02823
00730463
00731463
00002A23
00614463
00002A23
00615463
00602A23
00C005EF
00002C23
00002C23
00B02C23
08B00613
001606E7
00002E23
00002E23
00002E23
00D02E23
0000006F
00000009
00000000 12345678 0000000F
00000004 10000002 0000000F
00000008 12345668 0000000F
00000001 FBFBFBFB 00000002
0000000C 1234FB79 0000000F
00000010 000000FB 0000000F
00000014 00000001 0000000F
00000018 0000006C 0000000F
0000001C 00000080 0000000F

// ==== list.f ====
+incdir+.
core_pkg.sv
pc.sv
if_stage.sv
id_stage.sv
ex_stage.sv
regs.sv
ctrl.sv
core.sv
core_checker.sv
tb_core.sv
